// ==== logic/uart_cfg.svh ====
`ifndef UART_CFG_SVH
`define UART_CFG_SVH

// system clock in Hz, one period of 8 ns.
`define CLK_PER_SEC 125000000
// 16 clocks per bit at the system clock above.
`define DEFAULT_BAUD 7812500
// buffer entries, must be a power of two.
`define FIFO_DEPTH 8
`define WB_ADR_W 1

`endif

// ==== logic/uart_pkg.sv ====
`include "uart_cfg.svh"
`default_nettype none

package uart_pkg;

    typedef logic [7:0] byte_t;
    typedef logic [`WB_ADR_W-1:0] wb_adr_t; // 0 is the data register, 1 the level.
    typedef logic [$clog2(`FIFO_DEPTH)-1:0] fifo_ptr_t;
    typedef logic [$clog2(`FIFO_DEPTH):0] fifo_level_t;

    typedef enum logic [1:0] {
        rx_idle,
        rx_start,
        rx_data,
        rx_stop
    } rx_state_e;

    typedef enum logic [2:0] {
        tx_poll,
        tx_wait_level,
        tx_read,
        tx_wait_data,
        tx_shift
    } tx_state_e;

endpackage

`default_nettype wire

// ==== logic/wb_bus_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface wb_bus_if;

    logic cyc;
    logic stb;
    logic we;
    uart_pkg::wb_adr_t adr;
    uart_pkg::byte_t dat_w;
    uart_pkg::byte_t dat_r;
    logic ack;

    modport master (
        output cyc, stb, we, adr, dat_w,
        input dat_r, ack
    );

    modport slave (
        input cyc, stb, we, adr, dat_w,
        output dat_r, ack
    );

endinterface

`default_nettype wire

// ==== logic/uart_rx.sv ====
`timescale 1ns/1ps
`include "uart_cfg.svh"
`default_nettype none

module uart_rx #(
    parameter int clk_freq = `CLK_PER_SEC,
    parameter int baud = `DEFAULT_BAUD
) (
    input logic clk,
    input logic rstn,
    input logic rxd,
    output logic write_flag,
    output uart_pkg::byte_t read_data
);

    localparam int clk_per_bit = clk_freq / baud;
    localparam int clk_per_half = clk_per_bit / 2;
    localparam int cnt_w = $clog2(clk_per_bit);

    logic [4:0] sync;
    logic stable;
    logic line;
    logic [cnt_w-1:0] count;
    logic half_evt;
    logic bit_evt;
    logic [2:0] bit_idx;
    uart_pkg::byte_t shift;
    uart_pkg::rx_state_e state;

    // the synchronizer also filters chatter. the line only moves after five equal samples.
    assign stable = (sync == 5'b00000) || (sync == 5'b11111);
    assign half_evt = (count == cnt_w'(clk_per_half - 1));
    assign bit_evt = (count == cnt_w'(clk_per_bit - 1));

    always_ff @(posedge clk) begin
        if (!rstn) begin
            sync <= '1;
            line <= 1'b1;
        end else begin
            sync <= {sync[3:0], rxd};
            if (stable) begin
                line <= sync[4];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            count <= '0;
        end else if (state == uart_pkg::rx_idle || bit_evt ||
                     (state == uart_pkg::rx_start && half_evt)) begin
            count <= '0; // realign so data samples fall mid-bit.
        end else begin
            count <= count + cnt_w'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= uart_pkg::rx_idle;
            bit_idx <= '0;
            write_flag <= 1'b0;
        end else begin
            write_flag <= 1'b0;
            case (state)
                uart_pkg::rx_idle: begin
                    if (line && stable && !sync[4]) begin
                        state <= uart_pkg::rx_start; // filtered falling edge.
                    end
                end
                uart_pkg::rx_start: begin
                    if (half_evt) begin
                        bit_idx <= '0;
                        state <= line ? uart_pkg::rx_idle : uart_pkg::rx_data;
                    end
                end
                uart_pkg::rx_data: begin
                    if (bit_evt) begin
                        bit_idx <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7) begin
                            state <= uart_pkg::rx_stop;
                        end
                    end
                end
                uart_pkg::rx_stop: begin
                    if (bit_evt) begin
                        write_flag <= line; // a low stop bit drops the frame.
                        state <= uart_pkg::rx_idle;
                    end
                end
                default: state <= uart_pkg::rx_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == uart_pkg::rx_data && bit_evt) begin
            shift <= {line, shift[7:1]}; // lsb arrives first.
        end
        if (state == uart_pkg::rx_stop && bit_evt && line) begin
            read_data <= shift;
        end
    end

    a_flag_single: assert property (@(posedge clk) disable iff (!rstn)
        write_flag |=> !write_flag);

endmodule

`default_nettype wire

// ==== logic/rx_bus_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_bus_writer (
    input logic clk,
    input logic rstn,
    input logic write_flag,
    input uart_pkg::byte_t read_data,
    wb_bus_if.master bus
);

    logic busy;
    uart_pkg::byte_t data_q;

    assign bus.cyc = busy;
    assign bus.stb = busy;
    assign bus.we = 1'b1;
    assign bus.adr = '0;
    assign bus.dat_w = data_q;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            busy <= 1'b0;
        end else if (busy) begin
            if (bus.ack) begin
                busy <= 1'b0; // cyc drops in the cycle after ack.
            end
        end else if (write_flag) begin
            busy <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (write_flag && !busy) begin
            data_q <= read_data;
        end
    end

    a_wb_hold: assert property (@(posedge clk) disable iff (!rstn)
        (bus.stb |-> bus.cyc) and
        (bus.stb && !bus.ack |=> $stable(bus.adr) && $stable(bus.dat_w)));

endmodule

`default_nettype wire

// ==== logic/uart_tx.sv ====
`timescale 1ns/1ps
`include "uart_cfg.svh"
`default_nettype none

module uart_tx #(
    parameter int clk_freq = `CLK_PER_SEC,
    parameter int baud = `DEFAULT_BAUD
) (
    input logic clk,
    input logic rstn,
    wb_bus_if.master bus,
    output logic txd
);

    localparam int clk_per_bit = clk_freq / baud;
    localparam int cnt_w = $clog2(clk_per_bit);

    uart_pkg::tx_state_e state;
    logic [cnt_w-1:0] count;
    logic [3:0] bit_idx;
    logic [9:0] frame;
    logic req;
    logic bit_evt;

    assign req = (state == uart_pkg::tx_wait_level) || (state == uart_pkg::tx_wait_data);
    assign bit_evt = (count == cnt_w'(clk_per_bit - 1));

    assign bus.cyc = req;
    assign bus.stb = req;
    assign bus.we = 1'b0;
    assign bus.adr = (state == uart_pkg::tx_wait_level) ? uart_pkg::wb_adr_t'(1) : '0;
    assign bus.dat_w = '0;
    assign txd = frame[0];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= uart_pkg::tx_poll;
            frame <= '1;
            count <= '0;
            bit_idx <= '0;
        end else begin
            case (state)
                uart_pkg::tx_poll: state <= uart_pkg::tx_wait_level;
                uart_pkg::tx_wait_level: begin
                    if (bus.ack) begin
                        state <= (bus.dat_r != '0) ? uart_pkg::tx_read : uart_pkg::tx_poll;
                    end
                end
                uart_pkg::tx_read: state <= uart_pkg::tx_wait_data;
                uart_pkg::tx_wait_data: begin
                    if (bus.ack) begin
                        frame <= {1'b1, bus.dat_r, 1'b0}; // stop, data, start.
                        count <= '0;
                        bit_idx <= '0;
                        state <= uart_pkg::tx_shift;
                    end
                end
                uart_pkg::tx_shift: begin
                    if (bit_evt) begin
                        count <= '0;
                        frame <= {1'b1, frame[9:1]};
                        bit_idx <= bit_idx + 4'd1;
                        if (bit_idx == 4'd9) begin
                            state <= uart_pkg::tx_poll;
                        end
                    end else begin
                        count <= count + cnt_w'(1);
                    end
                end
                default: state <= uart_pkg::tx_poll;
            endcase
        end
    end

    a_idle_high: assert property (@(posedge clk) disable iff (!rstn)
        state != uart_pkg::tx_shift |-> txd);

endmodule

`default_nettype wire

// ==== logic/wb_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_arbiter (
    input logic clk,
    input logic rstn,
    wb_bus_if.slave m0,
    wb_bus_if.slave m1,
    wb_bus_if.master s
);

    logic busy;
    logic gnt;
    logic last;
    logic hold;
    logic pick;
    logic sel;

    // the grant stays while its master keeps cyc up. otherwise pick decides at once.
    assign hold = busy && (gnt ? m1.cyc : m0.cyc);
    assign pick = (m0.cyc && m1.cyc) ? !last : m1.cyc;
    assign sel = hold ? gnt : pick;

    assign s.cyc = sel ? m1.cyc : m0.cyc;
    assign s.stb = sel ? m1.stb : m0.stb;
    assign s.we = sel ? m1.we : m0.we;
    assign s.adr = sel ? m1.adr : m0.adr;
    assign s.dat_w = sel ? m1.dat_w : m0.dat_w;

    assign m0.ack = s.ack && !sel;
    assign m1.ack = s.ack && sel;
    assign m0.dat_r = sel ? '0 : s.dat_r;
    assign m1.dat_r = sel ? s.dat_r : '0;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            busy <= 1'b0;
            gnt <= 1'b0;
            last <= 1'b0;
        end else begin
            busy <= s.cyc;
            gnt <= sel;
            if (s.ack) begin
                last <= sel; // the other master wins the next tie.
            end
        end
    end

    a_ack_route: assert property (@(posedge clk) disable iff (!rstn)
        s.ack |-> (sel == $past(sel)) && (m0.ack ? $past(m0.stb) : $past(m1.stb)));

endmodule

`default_nettype wire

// ==== logic/byte_fifo_slave.sv ====
`timescale 1ns/1ps
`include "uart_cfg.svh"
`default_nettype none

module byte_fifo_slave (
    input logic clk,
    input logic rstn,
    wb_bus_if.slave bus
);

    uart_pkg::byte_t mem [`FIFO_DEPTH];
    uart_pkg::fifo_ptr_t wr_ptr;
    uart_pkg::fifo_ptr_t rd_ptr;
    uart_pkg::fifo_level_t level;
    logic req;
    logic full;
    logic empty;
    logic do_push;
    logic do_pop;

    assign req = bus.cyc && bus.stb && !bus.ack;
    assign full = (level == uart_pkg::fifo_level_t'(`FIFO_DEPTH));
    assign empty = (level == '0);
    assign do_push = req && bus.we && (bus.adr == '0) && !full;
    assign do_pop = req && !bus.we && (bus.adr == '0) && !empty;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            bus.ack <= 1'b0;
            wr_ptr <= '0;
            rd_ptr <= '0;
            level <= '0;
        end else begin
            bus.ack <= req && !(bus.we && (bus.adr == '0) && full); // full holds off the write.
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                level <= level + 1'b1;
            end else if (do_pop && !do_push) begin
                level <= level - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= bus.dat_w;
        end
        if (req && !bus.we) begin
            if (bus.adr != '0) begin
                bus.dat_r <= uart_pkg::byte_t'(level);
            end else begin
                bus.dat_r <= empty ? '0 : mem[rd_ptr];
            end
        end
    end

    a_level_max: assert property (@(posedge clk) disable iff (!rstn)
        level <= uart_pkg::fifo_level_t'(`FIFO_DEPTH));

endmodule

`default_nettype wire

// ==== logic/uart_echo_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_echo_top (
    input logic clk,
    input logic rstn,
    input logic rxd,
    output logic txd
);

    logic write_flag;
    uart_pkg::byte_t read_data;

    wb_bus_if wr_bus ();
    wb_bus_if tx_bus ();
    wb_bus_if fifo_bus ();

    uart_rx rx0 (
        .clk(clk),
        .rstn(rstn),
        .rxd(rxd),
        .write_flag(write_flag),
        .read_data(read_data)
    );

    rx_bus_writer wr0 (
        .clk(clk),
        .rstn(rstn),
        .write_flag(write_flag),
        .read_data(read_data),
        .bus(wr_bus.master)
    );

    uart_tx tx0 (
        .clk(clk),
        .rstn(rstn),
        .bus(tx_bus.master),
        .txd(txd)
    );

    // the writer sits on m0 and the transmitter on m1.
    wb_arbiter arb0 (
        .clk(clk),
        .rstn(rstn),
        .m0(wr_bus.slave),
        .m1(tx_bus.slave),
        .s(fifo_bus.master)
    );

    byte_fifo_slave fifo0 (
        .clk(clk),
        .rstn(rstn),
        .bus(fifo_bus.slave)
    );

endmodule

`default_nettype wire

// ==== tests/tb_uart_echo.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_uart_echo;

    localparam int num_rows = 18;
    localparam int bit_clks = 16;
    localparam int quiet_clks = 64;
    localparam int drain_clks = 40 * bit_clks;
    localparam int tail_clks = 12 * bit_clks;

    typedef struct packed {
        logic [7:0] data;
        logic stop;
        logic glitch;
        logic [7:0] gap; // idle bit times after the frame.
    } row_t;

    logic clk;
    logic rstn;
    logic rxd;
    logic txd;

    row_t rows [num_rows];
    logic [7:0] expected [$];
    integer seed;
    int errors;
    int echoed;
    int limit;
    int waited;

    uart_echo_top dut0 (
        .clk(clk),
        .rstn(rstn),
        .rxd(rxd),
        .txd(txd)
    );

    always #4 clk = ~clk;

    task automatic build_table();
        rows[0] = '{8'h55, 1'b1, 1'b0, 8'd2};
        for (int i = 1; i <= 12; i++) begin
            rows[i] = '{8'($random(seed)), 1'b1, 1'b0, 8'd0}; // back to back.
        end
        rows[13] = '{8'ha5, 1'b0, 1'b0, 8'd4}; // low stop bit, never echoed.
        rows[14] = '{8'h3c, 1'b1, 1'b0, 8'd2};
        rows[15] = '{8'h96, 1'b1, 1'b1, 8'd2};
        rows[16] = '{8'h00, 1'b1, 1'b0, 8'd2};
        rows[17] = '{8'hff, 1'b1, 1'b0, 8'd2};
    endtask

    function automatic int watchdog_cycles();
        int total;
        total = 10 + quiet_clks + drain_clks + tail_clks;
        for (int i = 0; i < num_rows; i++) begin
            total += (20 + int'(rows[i].gap)) * bit_clks + 40;
        end
        return total;
    endfunction

    task automatic drive_bit(input logic level);
        rxd = level;
        repeat (bit_clks) @(negedge clk);
    endtask

    task automatic send_row(input row_t row);
        if (row.glitch) begin
            rxd = 1'b0; // too short to pass the input filter.
            repeat (3) @(negedge clk);
            drive_bit(1'b1);
        end
        if (row.stop) begin
            expected.push_back(row.data);
        end
        drive_bit(1'b0);
        for (int i = 0; i < 8; i++) begin
            drive_bit(row.data[i]);
        end
        drive_bit(row.stop);
        rxd = 1'b1;
        repeat (int'(row.gap) * bit_clks) @(negedge clk);
    endtask

    task automatic watch_txd();
        logic [7:0] got;
        logic [7:0] want;
        forever begin
            @(negedge txd);
            repeat (bit_clks / 2) @(negedge clk); // middle of the start bit.
            if (txd !== 1'b0) begin
                $display("error at %0t: echo start bit is not low at its middle", $time);
                errors++;
            end
            for (int i = 0; i < 8; i++) begin
                repeat (bit_clks) @(negedge clk);
                got = {txd, got[7:1]};
            end
            repeat (bit_clks) @(negedge clk);
            if (txd !== 1'b1) begin
                $display("error at %0t: echo stop bit is %b, expected 1", $time, txd);
                errors++;
            end
            if (expected.size() == 0) begin
                $display("error at %0t: unexpected echo %h", $time, got);
                errors++;
            end else begin
                want = expected.pop_front();
                if (got !== want) begin
                    $display("error at %0t: echo got %h, expected %h", $time, got, want);
                    errors++;
                end
                echoed++;
            end
        end
    endtask

    task automatic run_watchdog(input int cycles);
        repeat (cycles) @(posedge clk);
        $display("timeout: the run did not finish within %0d clock cycles", cycles);
        $display("errors: %0d, echoed frames: %0d", errors, echoed);
        $display("Checks failed");
        $finish;
    endtask

    initial begin
        clk = 1'b0;
        rstn = 1'b0;
        rxd = 1'b1;
        seed = 32'h4ae4;
        errors = 0;
        echoed = 0;
        waited = 0;
        build_table();
        limit = watchdog_cycles();
        fork
            run_watchdog(limit);
        join_none
        repeat (10) @(negedge clk);
        rstn = 1'b1;
        fork
            watch_txd();
        join_none
        // the line stays idle so that any spurious echo shows up here.
        repeat (quiet_clks) begin
            @(negedge clk);
            if (txd !== 1'b1) begin
                $display("error at %0t: txd left idle before any input", $time);
                errors++;
            end
        end
        for (int i = 0; i < num_rows; i++) begin
            send_row(rows[i]);
        end
        while (expected.size() != 0 && waited < drain_clks) begin
            @(negedge clk);
            waited++;
        end
        repeat (tail_clks) @(negedge clk); // room for an extra frame to be caught.
        if (expected.size() != 0) begin
            $display("%0d expected echo bytes never arrived", expected.size());
            errors++;
        end
        $display("errors: %0d, echoed frames: %0d", errors, echoed);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+logic
logic/uart_pkg.sv
logic/wb_bus_if.sv
logic/uart_rx.sv
logic/rx_bus_writer.sv
logic/uart_tx.sv
logic/wb_arbiter.sv
logic/byte_fifo_slave.sv
logic/uart_echo_top.sv
tests/tb_uart_echo.sv

// ==== Makefile ====
TOP = tb_uart_echo

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f project.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f project.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qx "All checks passed"

clean:
	rm -rf obj_dir
